// File: Makefile
VERILATOR ?= verilator
TOP       ?= pipe_ctrl_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f files.f
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/ctrl_pkg.sv
package ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction opcodes
    ////////////////////////////////////////////////////////////////////////////

    // only these twelve are legal, anything else traps in decode
    typedef enum logic [5:0] {
        OP_ADD   = 6'o00,
        OP_SUB   = 6'o01,
        OP_AND   = 6'o02,
        OP_OR    = 6'o03,
        OP_XOR   = 6'o04,
        OP_ADDI  = 6'o05,
        OP_LOAD  = 6'o10,
        OP_STORE = 6'o11,
        OP_OUT   = 6'o12,
        OP_JUMP  = 6'o20,
        OP_NOP   = 6'o40,
        OP_HALT  = 6'o77
    } opcode_t;

    // alu function select, add doubles as the address adder
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_PASS = 3'd5
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // dispatch codes latched by the datapath
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2,
        MEM_OUT   = 2'd3
    } mem_op_t;

    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2,
        WB_PC   = 2'd3
    } wb_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // stage states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IS_IDLE, IS_FETCH, IS_DECODE, IS_EXEC, IS_IMM_FETCH, IS_IMM_EXEC, IS_ADDR
    } issue_state_t;

    typedef enum logic [2:0] {
        MS_IDLE, MS_DISPATCH, MS_RD_WAIT, MS_RD, MS_WR_WAIT, MS_WR, MS_HS_WAIT, MS_HS_HOLD
    } mem_state_t;

    typedef enum logic [2:0] {
        WS_IDLE, WS_DISPATCH, WS_ALU, WS_MEM, WS_PC
    } wb_state_t;

endpackage

// File: design/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  ctrl_pkg::opcode_t opcode,
    input  logic              i_odv,
    input  logic              wb_idle,
    output logic              i_req,
    output logic              ir_load,
    output logic              alu_en,
    output ctrl_pkg::alu_op_t alu_op,
    output logic              alu_src_imm,
    output logic              mar_load,
    output logic              illegal,
    output logic              issue_idle
);
    import ctrl_pkg::*;

    issue_state_t state;
    issue_state_t state_nxt;
    issue_state_t dec_nxt;
    alu_op_t      alu_dec;
    alu_op_t      alu_sel;
    logic         dec_legal;

    ////////////////////////////////////////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        alu_dec   = ALU_PASS;
        dec_nxt   = IS_IDLE;
        dec_legal = 1'b1;
        case (opcode)
            OP_ADD:   begin alu_dec = ALU_ADD; dec_nxt = IS_EXEC; end
            OP_SUB:   begin alu_dec = ALU_SUB; dec_nxt = IS_EXEC; end
            OP_AND:   begin alu_dec = ALU_AND; dec_nxt = IS_EXEC; end
            OP_OR:    begin alu_dec = ALU_OR;  dec_nxt = IS_EXEC; end
            OP_XOR:   begin alu_dec = ALU_XOR; dec_nxt = IS_EXEC; end
            // immediate needs the second instruction word first
            OP_ADDI:  begin alu_dec = ALU_ADD; dec_nxt = IS_IMM_FETCH; end
            OP_LOAD,
            OP_STORE,
            OP_OUT:   begin alu_dec = ALU_ADD; dec_nxt = IS_ADDR; end
            OP_JUMP,
            OP_NOP,
            OP_HALT:  dec_nxt = IS_IDLE;
            default:  dec_legal = 1'b0;
        endcase
    end

    // the second word overwrites the ir, so hold the function here
    always_ff @(posedge clk)
    begin
        if (state == IS_DECODE)
            alu_sel <= alu_dec;
    end

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= IS_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt   = state;
        i_req       = 1'b0;
        ir_load     = 1'b0;
        alu_en      = 1'b0;
        alu_src_imm = 1'b0;
        mar_load    = 1'b0;
        illegal     = 1'b0;
        case (state)
            IS_IDLE:
                if (wb_idle)
                    state_nxt = IS_FETCH;
            IS_FETCH:
            begin
                i_req   = 1'b1;
                ir_load = i_odv;
                if (i_odv)
                    state_nxt = IS_DECODE;
            end
            IS_DECODE:
            begin
                illegal   = !dec_legal;
                state_nxt = dec_nxt;
            end
            IS_EXEC:
            begin
                alu_en    = 1'b1;
                state_nxt = IS_IDLE;
            end
            IS_IMM_FETCH:
            begin
                i_req   = 1'b1;
                ir_load = i_odv;
                if (i_odv)
                    state_nxt = IS_IMM_EXEC;
            end
            IS_IMM_EXEC:
            begin
                alu_en      = 1'b1;
                alu_src_imm = 1'b1;
                state_nxt   = IS_IDLE;
            end
            IS_ADDR:
            begin
                mar_load  = 1'b1;
                state_nxt = IS_IDLE;
            end
            default:
                state_nxt = IS_IDLE;
        endcase
    end

    // latched function only while it is being used
    assign alu_op = (state == IS_EXEC || state == IS_IMM_EXEC) ? alu_sel : ALU_ADD;

    assign issue_idle = (state == IS_IDLE);

endmodule

// File: design/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_idle,
    input  logic              bus_free,
    input  logic              d_odv,
    input  logic              hs_in,
    input  ctrl_pkg::mem_op_t mem_op,
    output logic              d_req,
    output logic              d_we,
    output logic              mdr_load,
    output logic              hs_out,
    output logic              mem_idle
);
    import ctrl_pkg::*;

    mem_state_t state;
    mem_state_t state_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= MS_IDLE;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state and control outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        d_req     = 1'b0;
        d_we      = 1'b0;
        mdr_load  = 1'b0;
        hs_out    = 1'b0;
        case (state)
            MS_IDLE:
                if (issue_idle)
                    state_nxt = MS_DISPATCH;
            MS_DISPATCH:
                case (mem_op)
                    MEM_LOAD:  state_nxt = MS_RD_WAIT;
                    MEM_STORE: state_nxt = MS_WR_WAIT;
                    MEM_OUT:   state_nxt = MS_HS_WAIT;
                    default:   state_nxt = MS_IDLE;
                endcase
            // write-back owns the bus while it waits for its data
            MS_RD_WAIT:
                if (bus_free)
                    state_nxt = MS_RD;
            MS_RD:
            begin
                d_req    = 1'b1;
                mdr_load = d_odv;
                if (d_odv)
                    state_nxt = MS_IDLE;
            end
            MS_WR_WAIT:
                if (bus_free)
                    state_nxt = MS_WR;
            MS_WR:
            begin
                d_req = 1'b1;
                d_we  = 1'b1;
                if (d_odv)
                    state_nxt = MS_IDLE;
            end
            // level handshake with the peripheral
            MS_HS_WAIT:
                if (hs_in)
                    state_nxt = MS_HS_HOLD;
            MS_HS_HOLD:
            begin
                hs_out = 1'b1;
                if (!hs_in)
                    state_nxt = MS_IDLE;
            end
            default:
                state_nxt = MS_IDLE;
        endcase
    end

    assign mem_idle = (state == MS_IDLE);

endmodule

// File: design/pipe_ctrl.sv
`timescale 1ns/10ps

module pipe_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    // issue stage
    input  ctrl_pkg::opcode_t opcode,
    input  logic              i_odv,
    output logic              i_req,
    output logic              ir_load,
    output logic              alu_en,
    output ctrl_pkg::alu_op_t alu_op,
    output logic              alu_src_imm,
    output logic              mar_load,
    output logic              illegal,
    // memory stage
    input  ctrl_pkg::mem_op_t mem_op,
    input  logic              d_odv,
    input  logic              hs_in,
    output logic              d_req,
    output logic              d_we,
    output logic              mdr_load,
    output logic              hs_out,
    // write-back stage
    input  ctrl_pkg::wb_op_t  wb_op,
    output logic              rf_we,
    output logic              wb_sel_mem,
    output logic              pc_load
);

    ////////////////////////////////////////////////////////////////////////////
    // stage interlock, each stage starts only off the idle of the one before
    ////////////////////////////////////////////////////////////////////////////

    logic issue_idle;
    logic mem_idle;
    logic wb_idle;
    logic bus_free;

    issue_stage issue0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .opcode      (opcode),
        .i_odv       (i_odv),
        .wb_idle     (wb_idle),
        .i_req       (i_req),
        .ir_load     (ir_load),
        .alu_en      (alu_en),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .mar_load    (mar_load),
        .illegal     (illegal),
        .issue_idle  (issue_idle)
    );

    mem_stage mem0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .issue_idle (issue_idle),
        .bus_free   (bus_free),
        .d_odv      (d_odv),
        .hs_in      (hs_in),
        .mem_op     (mem_op),
        .d_req      (d_req),
        .d_we       (d_we),
        .mdr_load   (mdr_load),
        .hs_out     (hs_out),
        .mem_idle   (mem_idle)
    );

    // also arbitrates the data bus against the memory stage
    wb_stage wb0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_idle   (mem_idle),
        .d_odv      (d_odv),
        .wb_op      (wb_op),
        .rf_we      (rf_we),
        .wb_sel_mem (wb_sel_mem),
        .pc_load    (pc_load),
        .wb_idle    (wb_idle),
        .bus_free   (bus_free)
    );

endmodule

// File: design/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             mem_idle,
    input  logic             d_odv,
    input  ctrl_pkg::wb_op_t wb_op,
    output logic             rf_we,
    output logic             wb_sel_mem,
    output logic             pc_load,
    output logic             wb_idle,
    output logic             bus_free
);
    import ctrl_pkg::*;

    wb_state_t state;
    wb_state_t state_nxt;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= WS_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            WS_IDLE:
                if (mem_idle)
                    state_nxt = WS_DISPATCH;
            WS_DISPATCH:
                case (wb_op)
                    WB_ALU:  state_nxt = WS_ALU;
                    WB_MEM:  state_nxt = WS_MEM;
                    WB_PC:   state_nxt = WS_PC;
                    default: state_nxt = WS_IDLE;
                endcase
            WS_MEM:
                if (d_odv)
                    state_nxt = WS_IDLE;
            default:
                state_nxt = WS_IDLE;
        endcase
    end

    // memory data is written in the same cycle it arrives
    assign wb_sel_mem = (state == WS_MEM) && d_odv;
    assign rf_we      = (state == WS_ALU) || wb_sel_mem;
    assign pc_load    = (state == WS_PC);

    assign wb_idle  = (state == WS_IDLE);
    // keep the memory stage off the bus until our data shows up
    assign bus_free = (state != WS_MEM);

endmodule

// File: files.f
design/ctrl_pkg.sv
design/issue_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/pipe_ctrl.sv
tests/pipe_ctrl_assert.sv
tests/pipe_ctrl_tb.sv

// File: tests/pipe_ctrl_assert.sv
`timescale 1ns/10ps

module pipe_ctrl_assert (
    input logic              clk,
    input logic              arst_n,
    input logic              ir_load,
    input logic              alu_en,
    input logic              alu_src_imm,
    input logic              mar_load,
    input logic              illegal,
    input logic              d_req,
    input logic              d_we,
    input logic              d_odv,
    input logic              mdr_load,
    input logic              hs_in,
    input logic              hs_out,
    input logic              rf_we,
    input logic              wb_sel_mem,
    input logic              pc_load,
    input ctrl_pkg::mem_op_t mem_op
);
    import ctrl_pkg::*;

    logic after_illegal;

    // set by an illegal decode and cleared once the next word is loaded
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            after_illegal <= 1'b0;
        else if (illegal)
            after_illegal <= 1'b1;
        else if (ir_load)
            after_illegal <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // issue stage
    ////////////////////////////////////////////////////////////////////////////

    a_alu_single: assert property (@(posedge clk) disable iff (!arst_n)
        alu_en |=> !alu_en) else $error("alu_en high for more than one cycle");
    a_imm_exec: assert property (@(posedge clk) disable iff (!arst_n)
        alu_src_imm |-> alu_en) else $error("alu_src_imm without alu_en");
    a_illegal_single: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |=> !illegal) else $error("illegal high for more than one cycle");
    a_illegal_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        after_illegal |-> (!alu_en && !mar_load))
        else $error("alu_en or mar_load after an illegal opcode");

    ////////////////////////////////////////////////////////////////////////////
    // memory and write-back stages
    ////////////////////////////////////////////////////////////////////////////

    a_read_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (d_req && !d_odv) |=> d_req) else $error("d_req dropped before d_odv");
    a_mdr_load: assert property (@(posedge clk) disable iff (!arst_n)
        mdr_load == (d_req && !d_we && d_odv)) else $error("mdr_load not on read d_odv");
    a_write_req: assert property (@(posedge clk) disable iff (!arst_n)
        d_we |-> d_req) else $error("d_we without d_req");
    // a store writes for its whole request, a load never does
    a_bus_dir: assert property (@(posedge clk) disable iff (!arst_n)
        d_req |-> (d_we == (mem_op == MEM_STORE)))
        else $error("d_we does not match the memory operation");
    a_hs_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(hs_out) |-> $past(hs_in)) else $error("hs_out rose while hs_in was low");
    a_hs_fall: assert property (@(posedge clk) disable iff (!arst_n)
        (hs_out && !hs_in) |=> !hs_out) else $error("hs_out held after hs_in fell");
    a_pc_single: assert property (@(posedge clk) disable iff (!arst_n)
        pc_load |=> !pc_load) else $error("pc_load high for more than one cycle");
    a_rf_alu_single: assert property (@(posedge clk) disable iff (!arst_n)
        (rf_we && !wb_sel_mem) |=> !rf_we) else $error("alu write-back longer than a cycle");

endmodule

bind pipe_ctrl pipe_ctrl_assert checks0 (.*);

// File: tests/pipe_ctrl_tb.sv
`timescale 1ns/10ps

module pipe_ctrl_tb;
    import ctrl_pkg::*;

    localparam int num_steps      = 16;
    localparam int timeout_cycles = 40 * num_steps + 100;

    logic      clk;
    logic      arst_n;
    opcode_t   opcode;
    logic      i_odv;
    mem_op_t   mem_op;
    logic      d_odv;
    logic      hs_in;
    wb_op_t    wb_op;
    logic      i_req, ir_load, alu_en, alu_src_imm, mar_load, illegal;
    alu_op_t   alu_op;
    logic      d_req, d_we, mdr_load, hs_out;
    logic      rf_we, wb_sel_mem, pc_load;

    integer    seed = 32'h2c64;
    opcode_t   prog[$];
    opcode_t   alu_list[5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    int        i_wait, d_wait, p_wait;
    logic      periph_on;
    int        cycles;
    int        test_errors, n_passed, n_failed;

    // event counters kept by the monitor
    int        n_ir_load, n_alu_en, n_imm, n_illegal, n_mar_load;
    int        n_mdr_load, n_d_we, n_hs_rise, n_pc_load, n_rf_alu, n_rf_mem;
    alu_op_t   alu_log[64];
    logic      hs_out_q;
    int        base[11];

    pipe_ctrl dut0 (.*);

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // instruction, data bus and peripheral model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int pick_delay();
        return 1 + ({$random(seed)} % 4);
    endfunction

    always @(negedge clk)
    begin
        if (i_odv)
            i_odv = 1'b0;
        else if (i_req && prog.size() != 0)
        begin
            if (i_wait == 0)
                i_wait = pick_delay();
            i_wait = i_wait - 1;
            if (i_wait == 0)
            begin
                opcode = prog.pop_front();
                i_odv  = 1'b1;
            end
        end
        // late read data also returns while write-back holds the bus
        if (d_odv)
            d_odv = 1'b0;
        else if (d_req || !dut0.bus_free)
        begin
            if (d_wait == 0)
                d_wait = pick_delay();
            d_wait = d_wait - 1;
            if (d_wait == 0)
                d_odv = 1'b1;
        end
        if (!periph_on)
            hs_in = 1'b0;
        else if (hs_in == hs_out)
        begin
            if (p_wait == 0)
                p_wait = pick_delay();
            p_wait = p_wait - 1;
            if (p_wait == 0)
                hs_in = !hs_in;
        end
    end

    always @(posedge clk)
    begin
        if (alu_en && n_alu_en < 64)
            alu_log[n_alu_en] <= alu_op;
        n_ir_load  <= n_ir_load + int'(ir_load);
        n_alu_en   <= n_alu_en + int'(alu_en);
        n_imm      <= n_imm + int'(alu_src_imm);
        n_illegal  <= n_illegal + int'(illegal);
        n_mar_load <= n_mar_load + int'(mar_load);
        n_mdr_load <= n_mdr_load + int'(mdr_load);
        n_d_we     <= n_d_we + int'(d_we);
        n_hs_rise  <= n_hs_rise + int'(hs_out && !hs_out_q);
        n_pc_load  <= n_pc_load + int'(pc_load);
        n_rf_alu   <= n_rf_alu + int'(rf_we && !wb_sel_mem);
        n_rf_mem   <= n_rf_mem + int'(rf_we && wb_sel_mem);
        hs_out_q   <= hs_out;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, the pipeline stopped responding", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic alu_op_t expected_alu_fn(opcode_t op);
        case (op)
            OP_SUB:  return ALU_SUB;
            OP_AND:  return ALU_AND;
            OP_OR:   return ALU_OR;
            OP_XOR:  return ALU_XOR;
            default: return ALU_ADD;
        endcase
    endfunction

    task automatic take_snapshot();
        base = '{n_ir_load, n_alu_en, n_imm, n_illegal, n_mar_load, n_mdr_load,
                 n_d_we, n_hs_rise, n_pc_load, n_rf_alu, n_rf_mem};
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
        begin
            $display("test %s passed", name);
            n_passed++;
        end
        else
        begin
            $display("test %s failed with %0d errors", name, test_errors);
            n_failed++;
        end
        test_errors = 0;
    endtask

    // run a program and wait until issue stalls again and memory is done
    task automatic run_program(input mem_op_t m, input wb_op_t w);
        mem_op = m;
        wb_op  = w;
        take_snapshot();
        @(negedge clk);
        while (prog.size() != 0)
            @(negedge clk);
        while (!dut0.issue_idle)
            @(negedge clk);
        while (!i_req)
            @(negedge clk);
        @(negedge clk);
        while (!dut0.mem_idle)
            @(negedge clk);
        repeat (4) @(negedge clk);
        mem_op = MEM_NONE;
        wb_op  = WB_NONE;
        repeat (4) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        opcode    = OP_NOP;
        i_odv     = 1'b0;
        mem_op    = MEM_NONE;
        d_odv     = 1'b0;
        hs_in     = 1'b0;
        wb_op     = WB_NONE;
        periph_on = 1'b0;
        i_wait    = 0;
        d_wait    = 0;
        p_wait    = 0;
        cycles    = 0;
        test_errors = 0;
        n_passed  = 0;
        n_failed  = 0;
        {n_ir_load, n_alu_en, n_imm, n_illegal, n_mar_load, n_mdr_load} = '0;
        {n_d_we, n_hs_rise, n_pc_load, n_rf_alu, n_rf_mem} = '0;
        hs_out_q  = 1'b0;
        arst_n    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // nothing queued, so issue sits in fetch
        repeat (6)
        begin
            @(negedge clk);
            check_value("reset_idle", 0, int'(|{ir_load, alu_en, alu_src_imm, mar_load,
                illegal, d_req, d_we, mdr_load, hs_out, rf_we, wb_sel_mem, pc_load}));
        end
        check_value("reset_fetch", 1, int'(i_req));
        finish_test("reset_idle");

        foreach (alu_list[j])
            prog.push_back(alu_list[j]);
        run_program(MEM_NONE, WB_ALU);
        check_value("alu_ops count", 5, n_alu_en - base[1]);
        foreach (alu_list[j])
            check_value("alu_ops function", int'(expected_alu_fn(alu_list[j])),
                int'(alu_log[base[1] + j]));
        check_value("alu_ops rf_we", 1, int'(n_rf_alu != base[9]));
        check_value("alu_ops wb_sel_mem", 0, n_rf_mem - base[10]);
        finish_test("alu_ops");

        prog = '{OP_ADDI, OP_NOP};
        run_program(MEM_NONE, WB_ALU);
        check_value("addi ir_load", 2, n_ir_load - base[0]);
        check_value("addi alu_en", 1, n_alu_en - base[1]);
        check_value("addi alu_src_imm", 1, n_imm - base[2]);
        check_value("addi function", int'(ALU_ADD), int'(alu_log[base[1]]));
        finish_test("addi");

        prog = '{opcode_t'(6'o07)};
        run_program(MEM_NONE, WB_NONE);
        check_value("illegal pulse", 1, n_illegal - base[3]);
        check_value("illegal alu_en", 0, n_alu_en - base[1]);
        check_value("illegal mar_load", 0, n_mar_load - base[4]);
        finish_test("illegal");

        prog = '{OP_LOAD};
        run_program(MEM_LOAD, WB_MEM);
        check_value("load mar_load", 1, n_mar_load - base[4]);
        check_value("load mdr_load", 1, n_mdr_load - base[5]);
        check_value("load rf_we from memory", 1, int'(n_rf_mem != base[10]));
        finish_test("load");

        prog = '{OP_STORE};
        run_program(MEM_STORE, WB_NONE);
        check_value("store d_we", 1, int'(n_d_we != base[6]));
        check_value("store mdr_load", 0, n_mdr_load - base[5]);
        finish_test("store");

        periph_on = 1'b1;
        prog = '{OP_OUT};
        run_program(MEM_OUT, WB_NONE);
        periph_on = 1'b0;
        check_value("out hs_out rises", 1, n_hs_rise - base[7]);
        finish_test("out");

        prog = '{OP_JUMP};
        run_program(MEM_NONE, WB_PC);
        check_value("jump pc_load", 1, int'(n_pc_load != base[8]));
        check_value("jump alu_en", 0, n_alu_en - base[1]);
        finish_test("jump");

        $display("tests passed %0d failed %0d", n_passed, n_failed);
        if (n_failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
